/* Makefile */
TOP := tb_sova_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > run.log 2>&1 || echo "TB FAILED" >> run.log
	cat run.log
	@if grep -q "TB FAILED" run.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module sova_core \
		source/sova_pkg.sv source/acs_delta_stage.sv source/reliability_update.sv \
		source/reliability_store.sv source/soft_output_stage.sv source/sova_core.sv

clean:
	rm -rf obj_dir run.log

/* filelist.f */
+incdir+testbench
source/sova_pkg.sv
source/acs_delta_stage.sv
source/reliability_update.sv
source/reliability_store.sv
source/soft_output_stage.sv
source/sova_core.sv
testbench/tb_sova_core.sv

/* source/acs_delta_stage.sv */
`timescale 1ns/1ps

module acs_delta_stage
    import sova_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           step_valid,
    input  transition_t    branch_metric [NUM_STATES][NUM_STATES],
    output logic           delta_valid,
    output metric_t        delta [NUM_STATES][NUM_STATES],
    output trellis_state_t step_best,
    output metric_t        step_best_metric
);

    metric_t        path_metric [NUM_STATES];
    metric_t        cum_metric [NUM_STATES][NUM_STATES];
    metric_t        new_metric [NUM_STATES];
    trellis_state_t sel_pred [NUM_STATES];
    trellis_state_t new_best;

    // add and compare for every destination state
    always_comb begin
        for (int s = 0; s < NUM_STATES; s++) begin
            for (int k = 0; k < NUM_STATES; k++) begin
                cum_metric[s][k] = path_metric[k] + metric_t'(branch_metric[s][k]);
            end
            sel_pred[s] = first_min(cum_metric[s]);
            new_metric[s] = cum_metric[s][sel_pred[s]];
        end
        new_best = first_min(new_metric);
    end

    // survivor metrics only move on an accepted step
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_STATES; s++) begin
                path_metric[s] <= '0;
            end
        end else if (step_valid) begin
            path_metric <= new_metric;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            delta_valid <= 1'b0;
        end else begin
            delta_valid <= step_valid;
        end
    end

    // deltas measured from the selected survivor
    always_ff @(posedge clk) begin
        if (step_valid) begin
            for (int s = 0; s < NUM_STATES; s++) begin
                for (int k = 0; k < NUM_STATES; k++) begin
                    delta[s][k] <= cum_metric[s][k] - new_metric[s];
                end
            end
            step_best <= new_best;
            step_best_metric <= new_metric[new_best];
        end
    end

    // last cycle's winner holds the first zero delta of its row
    for (genvar g = 0; g < NUM_STATES; g++) begin : g_sel_check
        for (genvar k = 0; k < NUM_STATES; k++) begin : g_pred
            a_sel_zero : assert property (
                @(posedge clk) disable iff (reset)
                delta_valid && k <= int'($past(sel_pred[g]))
                    |-> (delta[g][k] == '0) == (k == int'($past(sel_pred[g])))
            );
        end
    end

endmodule

/* source/reliability_store.sv */
`timescale 1ns/1ps

module reliability_store
    import sova_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    delta_valid,
    input  metric_t next_window [NUM_STATES][NUM_STATES][TRACEBACK],
    output metric_t window [NUM_STATES][NUM_STATES][TRACEBACK]
);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_STATES; s++) begin
                for (int j = 0; j < NUM_STATES; j++) begin
                    for (int i = 0; i < TRACEBACK; i++) begin
                        window[s][j][i] <= '0;
                    end
                end
            end
        end else if (delta_valid) begin
            window <= next_window;
        end
    end

    // window holds between steps
    for (genvar s = 0; s < NUM_STATES; s++) begin : g_state
        for (genvar j = 0; j < NUM_STATES; j++) begin : g_entry
            for (genvar i = 0; i < TRACEBACK; i++) begin : g_depth
                a_hold : assert property (
                    @(posedge clk) disable iff (reset)
                    !delta_valid |=> $stable(window[s][j][i])
                );
            end
        end
    end

endmodule

/* source/reliability_update.sv */
`timescale 1ns/1ps

module reliability_update
    import sova_pkg::*;
(
    input  metric_t delta [NUM_STATES][NUM_STATES],
    input  metric_t window [NUM_STATES][NUM_STATES][TRACEBACK],
    output metric_t next_window [NUM_STATES][NUM_STATES][TRACEBACK]
);

    // window[s][j][i] is entry j of state s at depth i, depth 0 the newest
    for (genvar s = 0; s < NUM_STATES; s++) begin : g_state
        for (genvar j = 0; j < NUM_STATES; j++) begin : g_entry

            // newest depth comes straight from the deltas
            assign next_window[s][j][0] = delta[s][j];

            for (genvar i = 1; i < TRACEBACK; i++) begin : g_depth
                metric_t        cand [NUM_STATES];
                trellis_state_t pick;

                // min-plus over the four predecessors, same tie order as the ACS
                always_comb begin
                    for (int k = 0; k < NUM_STATES; k++) begin
                        cand[k] = window[k][j][i-1] + delta[s][k];
                    end
                    pick = first_min(cand);
                end

                assign next_window[s][j][i] = cand[pick];
            end

        end
    end

endmodule

/* source/soft_output_stage.sv */
`timescale 1ns/1ps

module soft_output_stage
    import sova_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           delta_valid,
    input  trellis_state_t step_best,
    input  metric_t        step_best_metric,
    input  metric_t        window [NUM_STATES][NUM_STATES][TRACEBACK],
    output logic           out_valid,
    output trellis_state_t best_state,
    output metric_t        best_metric,
    output metric_t        soft_reliability [NUM_STATES]
);

    logic           valid_d;
    trellis_state_t best_d;
    metric_t        best_metric_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= delta_valid;
        end
    end

    // line the best state up with the window written on the same edge
    always_ff @(posedge clk) begin
        best_d <= step_best;
        best_metric_d <= step_best_metric;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            best_state <= S0;
            best_metric <= '0;
            for (int j = 0; j < NUM_STATES; j++) begin
                soft_reliability[j] <= '0;
            end
        end else begin
            out_valid <= valid_d;
            if (valid_d) begin
                best_state <= best_d;
                best_metric <= best_metric_d;
                // oldest depth of the winning state
                for (int j = 0; j < NUM_STATES; j++) begin
                    soft_reliability[j] <= window[best_d][j][TRACEBACK-1];
                end
            end
        end
    end

    a_burst : assert property (
        @(posedge clk) disable iff (reset)
        out_valid && $past(out_valid) |-> $past(delta_valid, 2) && $past(delta_valid, 3)
    );

endmodule

/* source/sova_core.sv */
`timescale 1ns/1ps

module sova_core
    import sova_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           step_valid,
    input  transition_t    branch_metric [NUM_STATES][NUM_STATES],
    output logic           out_valid,
    output trellis_state_t best_state,
    output metric_t        best_metric,
    output metric_t        soft_reliability [NUM_STATES]
);

    logic           delta_valid;
    metric_t        delta [NUM_STATES][NUM_STATES];
    trellis_state_t step_best;
    metric_t        step_best_metric;
    metric_t        window [NUM_STATES][NUM_STATES][TRACEBACK];
    metric_t        next_window [NUM_STATES][NUM_STATES][TRACEBACK];

    // add-compare-select, one step per strobe
    acs_delta_stage u_acs (
        .clk              (clk),
        .reset            (reset),
        .step_valid       (step_valid),
        .branch_metric    (branch_metric),
        .delta_valid      (delta_valid),
        .delta            (delta),
        .step_best        (step_best),
        .step_best_metric (step_best_metric)
    );

    reliability_update u_update (
        .delta       (delta),
        .window      (window),
        .next_window (next_window)
    );

    reliability_store u_store (
        .clk         (clk),
        .reset       (reset),
        .delta_valid (delta_valid),
        .next_window (next_window),
        .window      (window)
    );

    // picks the best state's oldest row
    soft_output_stage u_out (
        .clk              (clk),
        .reset            (reset),
        .delta_valid      (delta_valid),
        .step_best        (step_best),
        .step_best_metric (step_best_metric),
        .window           (window),
        .out_valid        (out_valid),
        .best_state       (best_state),
        .best_metric      (best_metric),
        .soft_reliability (soft_reliability)
    );

endmodule

/* source/sova_pkg.sv */
package sova_pkg;

    // trellis geometry
    localparam int NUM_STATES = 4;
    localparam int TRACEBACK = 10;

    // datapath widths
    localparam int TRANSITION_W = 16;
    localparam int METRIC_W = 24;

    typedef logic [TRANSITION_W-1:0] transition_t;

    // path metrics, deltas and reliabilities wrap modulo 2^METRIC_W
    typedef logic [METRIC_W-1:0] metric_t;

    typedef enum logic [1:0] {
        S0,
        S1,
        S2,
        S3
    } trellis_state_t;

    // index of the first smallest value, lowest index wins a tie
    function automatic trellis_state_t first_min(input metric_t c [NUM_STATES]);
        trellis_state_t idx;
        idx = S0;
        for (int k = 1; k < NUM_STATES; k++) begin
            if (c[k] < c[idx]) begin
                idx = trellis_state_t'(k[1:0]);
            end
        end
        return idx;
    endfunction

endpackage

/* testbench/sova_model.svh */
`ifndef SOVA_MODEL_SVH
`define SOVA_MODEL_SVH

// reference copy of the decoder state, advanced once per accepted step
metric_t        m_path [NUM_STATES];
metric_t        m_delta [NUM_STATES][NUM_STATES];
metric_t        m_window [NUM_STATES][NUM_STATES][TRACEBACK];
trellis_state_t m_best;
metric_t        m_best_metric;

task automatic model_reset();
    for (int s = 0; s < NUM_STATES; s++) begin
        m_path[s] = '0;
        for (int j = 0; j < NUM_STATES; j++) begin
            m_delta[s][j] = '0;
            for (int i = 0; i < TRACEBACK; i++) begin
                m_window[s][j][i] = '0;
            end
        end
    end
    m_best = S0;
    m_best_metric = '0;
endtask

task automatic model_step(input transition_t bm [NUM_STATES][NUM_STATES]);
    metric_t c [NUM_STATES][NUM_STATES];
    metric_t surv [NUM_STATES];
    metric_t old [NUM_STATES][NUM_STATES][TRACEBACK];
    metric_t low;
    metric_t sum;
    int      win;
    // survivor per state, strict compare keeps the first minimum
    for (int s = 0; s < NUM_STATES; s++) begin
        for (int k = 0; k < NUM_STATES; k++) begin
            c[s][k] = m_path[k] + metric_t'(bm[s][k]);
        end
        surv[s] = c[s][0];
        for (int k = 1; k < NUM_STATES; k++) begin
            if (c[s][k] < surv[s]) begin
                surv[s] = c[s][k];
            end
        end
        for (int k = 0; k < NUM_STATES; k++) begin
            m_delta[s][k] = c[s][k] - surv[s];
        end
    end
    win = 0;
    for (int s = 1; s < NUM_STATES; s++) begin
        if (surv[s] < surv[win]) begin
            win = s;
        end
    end
    m_best = trellis_state_t'(win);
    m_best_metric = surv[win];
    // min-plus shift of the window, newest deltas at depth 0
    old = m_window;
    for (int s = 0; s < NUM_STATES; s++) begin
        for (int j = 0; j < NUM_STATES; j++) begin
            m_window[s][j][0] = m_delta[s][j];
            for (int i = 1; i < TRACEBACK; i++) begin
                low = old[0][j][i-1] + m_delta[s][0];
                for (int k = 1; k < NUM_STATES; k++) begin
                    sum = old[k][j][i-1] + m_delta[s][k];
                    if (sum < low) begin
                        low = sum;
                    end
                end
                m_window[s][j][i] = low;
            end
        end
    end
    m_path = surv;
endtask

`endif

/* testbench/tb_sova_core.sv */
`timescale 1ns/1ps

module tb_sova_core
    import sova_pkg::*;
();

    localparam int SEED = 32'hc449;
    localparam int NUM_ROWS = 64;
    localparam int MAX_CYCLES = NUM_ROWS + 20;

    logic           clk;
    logic           reset;
    logic           step_valid;
    transition_t    branch_metric [NUM_STATES][NUM_STATES];
    logic           out_valid;
    trellis_state_t best_state;
    metric_t        best_metric;
    metric_t        soft_reliability [NUM_STATES];

    // stimulus table and expected results per row
    logic           tbl_valid [NUM_ROWS];
    transition_t    tbl_bm [NUM_ROWS][NUM_STATES][NUM_STATES];
    trellis_state_t exp_state [NUM_ROWS];
    metric_t        exp_metric [NUM_ROWS];
    metric_t        exp_row [NUM_ROWS][NUM_STATES];
    int             exp_due [NUM_ROWS];
    int             pend_q [$];

    int cycle;
    int value_errors;
    int proto_errors;
    int rand_state;

    `include "sova_model.svh"

    sova_core UUT (
        .clk              (clk),
        .reset            (reset),
        .step_valid       (step_valid),
        .branch_metric    (branch_metric),
        .out_valid        (out_valid),
        .best_state       (best_state),
        .best_metric      (best_metric),
        .soft_reliability (soft_reliability)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_state(input string name, input trellis_state_t actual,
                               input trellis_state_t expected);
        if (actual !== expected) begin
            $display("ERR %0t %s exp %0d act %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_metric(input string name, input metric_t actual,
                                input metric_t expected);
        if (actual !== expected) begin
            $display("ERR %0t %s exp %0d act %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_row(input string name, input metric_t actual [NUM_STATES],
                             input metric_t expected [NUM_STATES]);
        for (int j = 0; j < NUM_STATES; j++) begin
            if (actual[j] !== expected[j]) begin
                $display("ERR %0t %s[%0d] exp %0d act %0d", $time, name, j,
                         expected[j], actual[j]);
                value_errors++;
            end
        end
    endtask

    // directed rows first, then idle gaps, then random back-to-back steps
    task automatic fill_step_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            tbl_valid[r] = 1'b1;
            for (int s = 0; s < NUM_STATES; s++) begin
                for (int k = 0; k < NUM_STATES; k++) begin
                    if (r == 0) begin
                        tbl_bm[r][s][k] = '0;
                    end else if (r == 1) begin
                        tbl_bm[r][s][k] = 16'd9;
                    end else if (r == 2) begin
                        // predecessors 1 and 3 tie
                        tbl_bm[r][s][k] = (k % 2 == 1) ? 16'd4 : 16'd6;
                    end else if (r == 3) begin
                        tbl_bm[r][s][k] = transition_t'((3 - s) + k);
                    end else if (r < 18) begin
                        tbl_bm[r][s][k] = transition_t'((s * 7 + k * 3 + r * 5) % 23);
                    end else if (r < 34) begin
                        tbl_bm[r][s][k] = transition_t'((s * 5 + k * 11 + r * 3) % 29);
                    end else begin
                        tbl_bm[r][s][k] = transition_t'($random(rand_state) & 32'hff);
                    end
                end
            end
            if (r >= 18 && r < 34 && (r % 3 == 0 || r == 25)) begin
                tbl_valid[r] = 1'b0;
            end
        end
    endtask

    initial begin : driver
        transition_t row_bm [NUM_STATES][NUM_STATES];
        metric_t     zero_row [NUM_STATES];
        metric_t     act_row [NUM_STATES];
        rand_state = SEED;
        value_errors = 0;
        proto_errors = 0;
        reset = 1'b1;
        step_valid = 1'b0;
        for (int s = 0; s < NUM_STATES; s++) begin
            zero_row[s] = '0;
            for (int k = 0; k < NUM_STATES; k++) begin
                branch_metric[s][k] = '0;
            end
        end
        fill_step_table();
        model_reset();

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // outputs cleared by reset
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("ERR %0t out_valid exp 0 act %b", $time, out_valid);
            value_errors++;
        end
        check_state("best_state", best_state, S0);
        check_metric("best_metric", best_metric, '0);
        for (int j = 0; j < NUM_STATES; j++) begin
            act_row[j] = soft_reliability[j];
        end
        check_row("soft_reliability", act_row, zero_row);

        @(posedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int s = 0; s < NUM_STATES; s++) begin
                for (int k = 0; k < NUM_STATES; k++) begin
                    row_bm[s][k] = tbl_bm[r][s][k];
                    branch_metric[s][k] <= tbl_bm[r][s][k];
                end
            end
            step_valid <= tbl_valid[r];
            if (tbl_valid[r]) begin
                model_step(row_bm);
                exp_state[r] = m_best;
                exp_metric[r] = m_best_metric;
                for (int j = 0; j < NUM_STATES; j++) begin
                    exp_row[r][j] = m_window[m_best][j][TRACEBACK-1];
                end
                // sampled on the next edge, seen three edges after that
                exp_due[r] = cycle + 4;
                pend_q.push_back(r);
            end
            @(posedge clk);
        end
        step_valid <= 1'b0;

        while (pend_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        $display("value errors %0d, protocol errors %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin : monitor
        int      idx;
        metric_t act_row [NUM_STATES];
        metric_t want_row [NUM_STATES];
        if (!reset) begin
            if (out_valid === 1'b1) begin
                if (pend_q.size() == 0) begin
                    $display("%0t: out_valid pulsed with no step outstanding", $time);
                    proto_errors++;
                end else begin
                    idx = pend_q.pop_front();
                    if (exp_due[idx] != cycle) begin
                        $display("%0t: result of row %0d came at cycle %0d instead of %0d",
                                 $time, idx, cycle, exp_due[idx]);
                        proto_errors++;
                    end
                    check_state("best_state", best_state, exp_state[idx]);
                    check_metric("best_metric", best_metric, exp_metric[idx]);
                    for (int j = 0; j < NUM_STATES; j++) begin
                        act_row[j] = soft_reliability[j];
                        want_row[j] = exp_row[idx][j];
                    end
                    check_row("soft_reliability", act_row, want_row);
                end
            end else if (pend_q.size() != 0 && exp_due[pend_q[0]] <= cycle) begin
                $display("%0t: no result for row %0d at cycle %0d", $time, pend_q[0], cycle);
                proto_errors++;
                void'(pend_q.pop_front());
            end
        end
    end

    // run limit
    initial cycle = 0;
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout, run passed %0d cycles with results outstanding", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule
